//--- build.f
src/cpuTypesPkg.sv
src/ctrlWordPkg.sv
src/opcodeDecoder.sv
src/interruptArbiter.sv
src/timingSequencer.sv
src/controlRom.sv
src/cpuControl.sv
sim/fetchHandshake_properties.sv
sim/cpuControlTb.sv

//--- Makefile
# Verilator build and run of the timing and control unit testbench
# the simulator exit status carries pass or fail

run: obj_dir/VcpuControlTb
	./obj_dir/VcpuControlTb

# rebuilt only when the file list or a source changes
obj_dir/VcpuControlTb: build.f $(wildcard src/*.sv sim/*.sv)
	verilator --binary --timing --assert -j 0 --top-module cpuControlTb -f build.f

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- sim/cpuControlTb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for the control top with an opcode memory model
// run through the Makefile where the exit status gives the result
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cpuControlTb;

    logic                 phi1 = 1'b0;
    logic                 rst = 1'b1;
    logic [7:0]           opcode = 8'hEA;   // driven by the memory model
    logic                 fetchAck = 1'b0;
    logic [7:0]           statusReg = 8'h00;
    logic                 nmi = 1'b0;
    logic                 irq = 1'b0;
    logic                 fetchReq;
    logic                 sync;
    ctrlWordPkg::ctrlWord ctrl;
    logic                 rstHandled;
    logic                 nmiHandled;
    logic                 irqHandled;

    logic [7:0]  prog [$];             // opcode stream served in order
    int          memIdx = 0;           // next opcode the memory hands out
    int          testIdx = 0;          // next opcode the tests expect
    logic [1:0]  ackWait = 2'd0;       // cycles left before fetchAck
    logic [31:0] lfsr = 32'h877;
    logic        wbOwed = 1'b0;        // previous instruction loads a register

    localparam logic [7:0] tableOps [7] = '{8'hEA, 8'hE8, 8'h18, 8'hA5, 8'hAD, 8'hE6, 8'h00};
    localparam logic [7:0] wbOps [8] = '{8'hE8, 8'hEA, 8'hA5, 8'h18, 8'hAD, 8'hEA, 8'hE6, 8'hEA};

    cpuControl dut0 (
        .phi1       (phi1),
        .rst        (rst),
        .opcode     (opcode),
        .fetchAck   (fetchAck),
        .statusReg  (statusReg),
        .nmi        (nmi),
        .irq        (irq),
        .fetchReq   (fetchReq),
        .sync       (sync),
        .ctrl       (ctrl),
        .rstHandled (rstHandled),
        .nmiHandled (nmiHandled),
        .irqHandled (irqHandled)
    );

    bind cpuControl fetchHandshake_properties props0 (
        .phi1       (phi1),
        .rst        (rst),
        .fetchReq   (fetchReq),
        .fetchAck   (fetchAck),
        .sync       (sync),
        .rstHandled (rstHandled),
        .nmiHandled (nmiHandled),
        .irqHandled (irqHandled)
    );

    always #2 phi1 = ~phi1;  // 4 ns

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [1:0] ackDelay();
        logic [1:0] d;
        for (int i = 0; i < 2; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            d[i] = lfsr[0];
        end
        return d;
    endfunction

    // opcode memory answering fetchReq after 0 to 3 cycles
    always @(negedge phi1) begin
        if (rst) begin
            fetchAck <= 1'b0;
            ackWait  <= 2'd0;
        end else if (fetchReq && !fetchAck) begin
            if (ackWait == 2'd0) begin
                opcode   <= (memIdx < prog.size()) ? prog[memIdx] : 8'hEA;  // NOP past the end
                fetchAck <= 1'b1;
            end else begin
                ackWait <= ackWait - 2'd1;
            end
        end else if (!fetchReq && fetchAck) begin
            fetchAck <= 1'b0;          // phase 4
            memIdx   <= memIdx + 1;
            ackWait  <= ackDelay();
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic abortRun(input string why);
        $display("%s at %0t", why, $time);
        $display("tests failed");
        $fatal(1, "timeout");
    endtask

    // cycle counts from the opcode table with T1 included
    function automatic int baseCycles(input logic [7:0] op, input logic z);
        case (op)
            8'hA5: return 3;
            8'hAD: return 4;
            8'hE6: return 5;
            8'h00: return 7;
            8'hD0: return z ? 2 : 3;  // one more when the branch is taken
            default: return 2;
        endcase
    endfunction

    function automatic logic loadsReg(input logic [7:0] op);
        return (op == 8'hE8) || (op == 8'hA5) || (op == 8'hAD);
    endfunction

    task automatic loadProgram();
        for (int r = 0; r < 3; r++)
            foreach (tableOps[i]) prog.push_back(tableOps[i]);
        prog.push_back(8'hD0);  // BNE with Z set
        prog.push_back(8'hD0);  // BNE with Z clear
        foreach (wbOps[i]) prog.push_back(wbOps[i]);
        prog.push_back(8'hE8);  // INX host, its load lands inside the irq sequence
        repeat (3) prog.push_back(8'hEA);  // hosts for the other interrupt tests
    endtask

    // one instruction from T1 to the next T1 starting where fetchReq is high
    task automatic runInstr(input logic zSet, input logic iSet, input logic [1:0] raise,
                            input cpuTypesPkg::intSource expInt);
        logic [7:0]  op;
        logic [31:0] wbMask;
        logic [31:0] wrMask;
        logic [31:0] expWb;
        logic [31:0] expWr;
        int          n;
        int          t;
        int          expLow;
        int          lowCnt;
        int          nmiAt;
        int          irqAt;
        int          rstAt;
        op = prog[testIdx];
        testIdx++;
        statusReg <= {5'b0, iSet, zSet, 1'b0};
        if (raise[0]) irq <= 1'b1;
        if (raise[1]) nmi <= 1'b1;
        n = baseCycles(op, zSet);
        expLow = (expInt == cpuTypesPkg::none) ? n - 1 : n + 6;  // 7 more for the sequence
        expWb = '0;
        expWr = '0;
        expWb[0] = wbOwed;
        if (expInt != cpuTypesPkg::none) expWb[n] = loadsReg(op);  // lands in seq T2
        for (int i = 0; i < expLow; i++) begin
            if (i < n - 1) begin
                t = i + 2;
                expWr[i] = (op == 8'hE6 && t >= 4) || (op == 8'h00 && t >= 3 && t <= 5);
            end else begin
                t = i - n + 2;  // T-state inside the interrupt sequence
                expWr[i] = (t >= 3) && (t <= 5);
            end
        end
        check("fetchReq at T1", 32'(fetchReq), 32'd1);
        n = 0;
        while (fetchReq) begin  // T1 is stretched by a late ack
            check("sync", 32'(sync), 32'd1);
            if (n == 8) abortRun("fetch was never acknowledged");
            n++;
            @(negedge phi1);
        end
        lowCnt = 0;
        wbMask = '0;
        wrMask = '0;
        nmiAt = -1;
        irqAt = -1;
        rstAt = -1;
        while (!fetchReq) begin
            check("sync", 32'(sync), 32'd0);
            if (ctrl.regWriteback) wbMask[lowCnt] = 1'b1;
            if (ctrl.writeMem) wrMask[lowCnt] = 1'b1;
            if (rstHandled) rstAt = lowCnt;
            if (nmiHandled) begin
                nmiAt = lowCnt;
                nmi <= 1'b0;
            end
            if (irqHandled) begin
                irqAt = lowCnt;
                irq <= 1'b0;
            end
            lowCnt++;
            if (lowCnt > 16) abortRun("fetchReq stayed low too long");
            @(negedge phi1);
        end
        check("cycles with fetchReq low", lowCnt, expLow);
        check("regWriteback cycles", wbMask, expWb);
        check("writeMem cycles", wrMask, expWr);
        check("rstHandled cycle", rstAt, -1);
        check("nmiHandled cycle", nmiAt, (expInt == cpuTypesPkg::nmiI) ? expLow - 1 : -1);
        check("irqHandled cycle", irqAt, (expInt == cpuTypesPkg::irqI) ? expLow - 1 : -1);
        check("opcodes served", memIdx, testIdx);
        wbOwed = (expInt == cpuTypesPkg::none) ? loadsReg(op) : 1'b0;
    endtask

    task automatic resetTest();
        int n;
        for (n = 0; n < 8; n++) begin
            @(negedge phi1);
            check("fetchReq", 32'(fetchReq), 32'd0);
            check("sync", 32'(sync), 32'd0);
            check("writeMem", 32'(ctrl.writeMem), 32'd0);
            check("handled", {29'b0, rstHandled, nmiHandled, irqHandled}, 32'd0);
        end
        rst <= 1'b0;
        n = 1;  // this cycle is T1 of the reset sequence
        @(negedge phi1);
        while (!fetchReq) begin
            n++;
            check("writeMem", 32'(ctrl.writeMem), 32'd0);
            check("vectorFetch", 32'(ctrl.vectorFetch), 32'(n >= 6));
            check("rstHandled", 32'(rstHandled), 32'(n == 7));
            if (n > 12) abortRun("reset sequence never reached a fetch");
            @(negedge phi1);
        end
        check("reset sequence cycles", n, 7);
    endtask

    task automatic cycleTest();
        repeat (21) runInstr(1'b0, 1'b0, 2'b00, cpuTypesPkg::none);
    endtask

    task automatic branchTest();
        runInstr(1'b1, 1'b0, 2'b00, cpuTypesPkg::none);  // not taken
        runInstr(1'b0, 1'b0, 2'b00, cpuTypesPkg::none);  // taken
    endtask

    task automatic writebackTest();
        repeat (8) runInstr(1'b0, 1'b0, 2'b00, cpuTypesPkg::none);
    endtask

    task automatic interruptTest();
        runInstr(1'b0, 1'b0, 2'b01, cpuTypesPkg::irqI);
        runInstr(1'b0, 1'b1, 2'b01, cpuTypesPkg::none);  // masked by I
        runInstr(1'b0, 1'b0, 2'b11, cpuTypesPkg::nmiI);  // nmi wins
        runInstr(1'b0, 1'b0, 2'b00, cpuTypesPkg::irqI);  // irq still up and served next
    endtask

    initial begin
        loadProgram();
        resetTest();
        cycleTest();
        branchTest();
        writebackTest();
        interruptTest();
        $display("all tests passed");
        $finish;
    end

endmodule

//--- sim/fetchHandshake_properties.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch handshake and handled strobe assertions
// bound into the control top from the testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fetchHandshake_properties (
    input logic phi1,
    input logic rst,
    input logic fetchReq,
    input logic fetchAck,
    input logic sync,
    input logic rstHandled,
    input logic nmiHandled,
    input logic irqHandled
);

    logic anyHandled;

    assign anyHandled = rstHandled || nmiHandled || irqHandled;

    // request holds until memory answers
    reqHeld: assert property (@(posedge phi1) disable iff (rst)
        fetchReq && !fetchAck |=> fetchReq)
        else $error("fetchReq dropped before fetchAck arrived");

    // the opcode is taken on the first ack edge
    reqDrops: assert property (@(posedge phi1) disable iff (rst)
        fetchReq && fetchAck |=> !fetchReq)
        else $error("fetchReq still high after fetchAck");

    syncInFetch: assert property (@(posedge phi1) disable iff (rst)
        fetchReq |-> sync)
        else $error("fetchReq high outside a sync cycle");

    // a strobe marks only the last cycle of a sequence
    singlePulse: assert property (@(posedge phi1) disable iff (rst)
        anyHandled |=> !anyHandled)
        else $error("handled strobe longer than one cycle");

    // the next fetch starts right after the sequence
    handledThenFetch: assert property (@(posedge phi1) disable iff (rst)
        anyHandled |=> fetchReq)
        else $error("no fetch after the handled strobe");

endmodule

//--- src/cpuControl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// timing and control top: decoder, arbiter, sequencer and rom
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cpuControl (
    input  logic                 phi1,
    input  logic                 rst,
    input  logic [7:0]           opcode,
    input  logic                 fetchAck,
    input  logic [7:0]           statusReg,  // I at bit 2, Z at bit 1
    input  logic                 nmi,
    input  logic                 irq,
    output logic                 fetchReq,
    output logic                 sync,
    output ctrlWordPkg::ctrlWord ctrl,
    output logic                 rstHandled,
    output logic                 nmiHandled,
    output logic                 irqHandled
);

    cpuTypesPkg::decodeInfo decInfo;
    cpuTypesPkg::intSource  pending;
    cpuTypesPkg::intSource  active;
    cpuTypesPkg::seqState   state;
    cpuTypesPkg::tState     tNow;
    cpuTypesPkg::instrClass activeClass;
    logic [7:0]             activeOpcode;
    logic                   deferWb;
    logic                   intTaken;
    logic                   intDone;

    opcodeDecoder decoder0 (
        .opcode (opcode),
        .info   (decInfo)
    );

    interruptArbiter arbiter0 (
        .phi1       (phi1),
        .rst        (rst),
        .nmi        (nmi),
        .irq        (irq),
        .irqMask    (statusReg[2]),
        .intTaken   (intTaken),
        .intDone    (intDone),
        .pending    (pending),
        .active     (active),
        .rstHandled (rstHandled),
        .nmiHandled (nmiHandled),
        .irqHandled (irqHandled)
    );

    timingSequencer sequencer0 (
        .phi1         (phi1),
        .rst          (rst),
        .fetchAck     (fetchAck),
        .opcode       (opcode),
        .info         (decInfo),
        .zeroFlag     (statusReg[1]),
        .pending      (pending),
        .fetchReq     (fetchReq),
        .sync         (sync),
        .state        (state),
        .tNow         (tNow),
        .activeOpcode (activeOpcode),
        .activeClass  (activeClass),
        .deferWb      (deferWb),
        .intTaken     (intTaken),
        .intDone      (intDone)
    );

    controlRom rom0 (
        .state        (state),
        .tNow         (tNow),
        .activeOpcode (activeOpcode),
        .activeClass  (activeClass),
        .intActive    (active),
        .deferWb      (deferWb),
        .ctrl         (ctrl)
    );

endmodule

//--- src/controlRom.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational control store, indexed by state, class, opcode and T
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module controlRom (
    input  cpuTypesPkg::seqState   state,
    input  cpuTypesPkg::tState     tNow,
    input  logic [7:0]             activeOpcode,
    input  cpuTypesPkg::instrClass activeClass,
    input  cpuTypesPkg::intSource  intActive,
    input  logic                   deferWb,
    output ctrlWordPkg::ctrlWord   ctrl
);

    // shared by BRK, nmi/irq entry and reset: pushes in T3-T5, vector in T6-T7
    function automatic ctrlWordPkg::ctrlWord stackSeq(input cpuTypesPkg::tState t,
                                                     input logic isBrk,
                                                     input logic pushEn);
        ctrlWordPkg::ctrlWord w;
        w = '0;
        case (t)
            cpuTypesPkg::T2: begin
                w.readMem = 1'b1;
                w.pcInc   = isBrk;     // BRK skips its padding byte
            end
            cpuTypesPkg::T3, cpuTypesPkg::T4, cpuTypesPkg::T5: begin
                w.stackDec = 1'b1;     // PCH, PCL, P
                w.writeMem = pushEn;   // reset does dummy pushes
            end
            cpuTypesPkg::T6, cpuTypesPkg::T7: begin
                w.vectorFetch = 1'b1;
                w.readMem     = 1'b1;
            end
            default: ;
        endcase
        return w;
    endfunction

    always_comb begin
        ctrl = '0;
        case (state)
            cpuTypesPkg::fetch: begin
                ctrl.readMem = 1'b1;  // opcode read
                ctrl.pcInc   = 1'b1;
            end
            cpuTypesPkg::resetSeq: ctrl = stackSeq(tNow, 1'b0, 1'b0);
            cpuTypesPkg::intSeq:
                ctrl = stackSeq(tNow, 1'b0, intActive != cpuTypesPkg::rstI);
            default: begin  // exec
                case (activeClass)
                    cpuTypesPkg::norm: begin
                        if (activeOpcode == 8'hE8)
                            ctrl.alu = ctrlWordPkg::inc;        // INX, X + 1
                        if ((activeOpcode == 8'hA5 && tNow == cpuTypesPkg::T2) ||
                            (activeOpcode == 8'hAD && tNow != cpuTypesPkg::T4)) begin
                            ctrl.readMem = 1'b1;                // operand bytes
                            ctrl.pcInc   = 1'b1;
                        end
                        if ((activeOpcode == 8'hA5 && tNow == cpuTypesPkg::T3) ||
                            (activeOpcode == 8'hAD && tNow == cpuTypesPkg::T4))
                            ctrl.readMem = 1'b1;                // data read
                    end
                    cpuTypesPkg::rmw: begin  // INC zp
                        ctrl.readMem  = (tNow == cpuTypesPkg::T2) || (tNow == cpuTypesPkg::T3);
                        ctrl.pcInc    = (tNow == cpuTypesPkg::T2);
                        ctrl.writeMem = (tNow == cpuTypesPkg::T4) || (tNow == cpuTypesPkg::T5);
                        if (tNow == cpuTypesPkg::T4)
                            ctrl.alu = ctrlWordPkg::inc;  // dummy write, then result
                    end
                    cpuTypesPkg::branch: begin
                        if (tNow == cpuTypesPkg::T2) begin
                            ctrl.readMem = 1'b1;  // offset byte
                            ctrl.pcInc   = 1'b1;
                        end else begin
                            ctrl.alu = ctrlWordPkg::add;  // taken, pc + offset
                        end
                    end
                    default: ctrl = stackSeq(tNow, 1'b1, 1'b1);  // BRK
                endcase
            end
        endcase
        ctrl.regWriteback = deferWb;  // previous instruction's register load
    end

endmodule

//--- src/timingSequencer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// T-state machine: fetch handshake in T1, then T2..Tn,
// and interrupt entry at the end of each instruction
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module timingSequencer (
    input  logic                   phi1,
    input  logic                   rst,
    input  logic                   fetchAck,
    input  logic [7:0]             opcode,
    input  cpuTypesPkg::decodeInfo info,      // decode of the opcode bus
    input  logic                   zeroFlag,
    input  cpuTypesPkg::intSource  pending,
    output logic                   fetchReq,
    output logic                   sync,
    output cpuTypesPkg::seqState   state,
    output cpuTypesPkg::tState     tNow,
    output logic [7:0]             activeOpcode,
    output cpuTypesPkg::instrClass activeClass,
    output logic                   deferWb,
    output logic                   intTaken,
    output logic                   intDone
);

    cpuTypesPkg::decodeInfo infoReg;  // decode of the instruction in flight
    logic       takeBr;               // BNE with Z clear, one extra cycle
    logic       prevWb;               // writeback owed by the previous instruction
    logic [2:0] lastT;
    logic       ackNow;
    logic       execEnd;
    logic       seqEnd;
    logic       intNext;

    assign lastT   = infoReg.cycles + {2'b00, takeBr};
    assign ackNow  = (state == cpuTypesPkg::fetch) && fetchReq && fetchAck;
    assign execEnd = (state == cpuTypesPkg::exec) && (tNow == cpuTypesPkg::tState'(lastT));
    assign seqEnd  = ((state == cpuTypesPkg::intSeq) || (state == cpuTypesPkg::resetSeq))
                     && (tNow == cpuTypesPkg::T7);
    assign intNext = execEnd && (pending != cpuTypesPkg::none);  // sampled in last cycle

    // reset sequence claims the rst request in its first cycle
    assign intTaken = intNext ||
                      ((state == cpuTypesPkg::resetSeq) && (tNow == cpuTypesPkg::T1));
    assign intDone  = seqEnd;

    assign sync        = (state == cpuTypesPkg::fetch);
    assign activeClass = infoReg.cls;
    assign deferWb     = prevWb && (tNow == cpuTypesPkg::T2);

    always_ff @(posedge phi1) begin
        if (rst) begin
            state    <= cpuTypesPkg::resetSeq;
            tNow     <= cpuTypesPkg::T1;
            fetchReq <= 1'b0;
            prevWb   <= 1'b0;
        end else begin
            case (state)
                cpuTypesPkg::fetch: begin
                    if (ackNow) begin
                        fetchReq <= 1'b0;       // phase 3, wait for ack to drop
                        state    <= cpuTypesPkg::exec;
                        tNow     <= cpuTypesPkg::T2;
                    end else if (!fetchAck) begin
                        fetchReq <= 1'b1;       // only once the old ack is gone
                    end
                end
                cpuTypesPkg::exec: begin
                    if (execEnd) begin
                        prevWb <= infoReg.wb;   // shows up in the next T2
                        tNow   <= cpuTypesPkg::T1;
                        if (intNext) begin
                            state <= cpuTypesPkg::intSeq;  // replaces the fetch
                        end else begin
                            state    <= cpuTypesPkg::fetch;
                            fetchReq <= !fetchAck;
                        end
                    end else begin
                        tNow <= cpuTypesPkg::tState'(tNow + 3'd1);
                    end
                end
                default: begin  // resetSeq and intSeq, fixed 7 cycles
                    if (seqEnd) begin
                        prevWb   <= 1'b0;       // already delivered in T2
                        state    <= cpuTypesPkg::fetch;
                        tNow     <= cpuTypesPkg::T1;
                        fetchReq <= !fetchAck;
                    end else begin
                        tNow <= cpuTypesPkg::tState'(tNow + 3'd1);
                    end
                end
            endcase
        end
    end

    // instruction register, loaded on the ack edge
    always_ff @(posedge phi1) begin
        if (ackNow) begin
            activeOpcode <= opcode;
            infoReg      <= info;
            takeBr       <= (info.cls == cpuTypesPkg::branch) && !zeroFlag;
        end
    end

endmodule

//--- src/interruptArbiter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// latches rst/nmi/irq, offers the winner to the sequencer
// and raises the handled strobe in the last cycle of its sequence
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module interruptArbiter (
    input  logic                  phi1,
    input  logic                  rst,
    input  logic                  nmi,
    input  logic                  irq,
    input  logic                  irqMask,   // I flag
    input  logic                  intTaken,  // sequencer accepted pending
    input  logic                  intDone,   // last cycle of the sequence
    output cpuTypesPkg::intSource pending,
    output cpuTypesPkg::intSource active,
    output logic                  rstHandled,
    output logic                  nmiHandled,
    output logic                  irqHandled
);

    logic rstReq;    // reset vector still owed
    logic nmiPrev;
    logic nmiLatch;  // edge seen, not yet serviced
    logic nmiEdge;

    assign nmiEdge = nmi && !nmiPrev;

    // priority rst > nmi > irq, the fresh nmi edge counts the same cycle
    always_comb begin
        if (rstReq)                  pending = cpuTypesPkg::rstI;
        else if (nmiLatch || nmiEdge) pending = cpuTypesPkg::nmiI;
        else if (irq && !irqMask)    pending = cpuTypesPkg::irqI;  // level, maskable
        else                         pending = cpuTypesPkg::none;
    end

    always_ff @(posedge phi1) begin
        nmiPrev <= nmi;  // plain edge sampler
    end

    always_ff @(posedge phi1) begin
        if (rst) begin
            rstReq   <= 1'b1;
            nmiLatch <= 1'b0;
            active   <= cpuTypesPkg::none;
        end else begin
            if (intTaken && pending == cpuTypesPkg::rstI)
                rstReq <= 1'b0;
            if (intTaken && pending == cpuTypesPkg::nmiI)
                nmiLatch <= 1'b0;
            else if (nmiEdge)
                nmiLatch <= 1'b1;
            if (intTaken)
                active <= pending;          // frozen for the whole sequence
            else if (intDone)
                active <= cpuTypesPkg::none;
        end
    end

    // one cycle strobes, exactly the last cycle of the sequence
    assign rstHandled = intDone && (active == cpuTypesPkg::rstI);
    assign nmiHandled = intDone && (active == cpuTypesPkg::nmiI);
    assign irqHandled = intDone && (active == cpuTypesPkg::irqI);

endmodule

//--- src/opcodeDecoder.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sorts an opcode into class, base cycle count and writeback flag
// purely combinational, sits on the opcode bus in front of the sequencer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module opcodeDecoder (
    input  logic [7:0]             opcode,
    output cpuTypesPkg::decodeInfo info
);

    always_comb begin
        // unknown opcodes fall through as a 2 cycle NOP
        info = '{cls: cpuTypesPkg::norm, cycles: 3'd2, wb: 1'b0};
        case (opcode)
            8'hEA: info = '{cls: cpuTypesPkg::norm, cycles: 3'd2, wb: 1'b0};  // NOP
            8'hE8: info = '{cls: cpuTypesPkg::norm, cycles: 3'd2, wb: 1'b1};  // INX
            8'h18: info = '{cls: cpuTypesPkg::norm, cycles: 3'd2, wb: 1'b0};  // CLC
            8'hA5: info = '{cls: cpuTypesPkg::norm, cycles: 3'd3, wb: 1'b1};  // LDA zp
            8'hAD: info = '{cls: cpuTypesPkg::norm, cycles: 3'd4, wb: 1'b1};  // LDA abs
            8'hE6: info = '{cls: cpuTypesPkg::rmw, cycles: 3'd5, wb: 1'b0};   // INC zp
            // BNE, base count only; sequencer adds the taken cycle
            8'hD0: info = '{cls: cpuTypesPkg::branch, cycles: 3'd2, wb: 1'b0};
            8'h00: info = '{cls: cpuTypesPkg::brk, cycles: 3'd7, wb: 1'b0};   // BRK
            default: ;
        endcase
    end

endmodule

//--- src/ctrlWordPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control word seen by the datapath, one per phi1 cycle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ctrlWordPkg;

    typedef enum logic [1:0] {
        pass = 2'd0,  // operand straight through
        inc  = 2'd1,  // operand + 1
        add  = 2'd2,  // pc + branch offset
        cmp  = 2'd3   // subtract, flags only
    } aluOp;

    // bit order from msb down, 8 bits in all
    typedef struct packed {
        logic pcInc;         // advance program counter
        logic readMem;       // drive a bus read
        logic writeMem;      // drive a bus write
        logic stackDec;      // push, sp - 1
        logic vectorFetch;   // read from the interrupt vector
        logic regWriteback;  // load the deferred result into A/X
        aluOp alu;
    } ctrlWord;

endpackage

//--- src/cpuTypesPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the timing and control unit
// referenced by scoped name from decoder, arbiter, sequencer and rom
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cpuTypesPkg;

    // instruction groups, each with its own T-state pattern
    typedef enum logic [1:0] {
        norm   = 2'd0,  // fixed cycle, no memory write
        rmw    = 2'd1,  // read-modify-write
        branch = 2'd2,  // conditional branch, extra cycle when taken
        brk    = 2'd3   // software break, same shape as an interrupt
    } instrClass;

    // what the sequencer is doing right now
    typedef enum logic [1:0] {
        resetSeq = 2'd0,
        fetch    = 2'd1,  // T1, opcode handshake in progress
        exec     = 2'd2,  // T2..Tn of a fetched instruction
        intSeq   = 2'd3   // 7 cycle interrupt entry
    } seqState;

    // encoding equals the cycle number, so a count compares directly
    typedef enum logic [2:0] {
        T1 = 3'd1,
        T2 = 3'd2,
        T3 = 3'd3,
        T4 = 3'd4,
        T5 = 3'd5,
        T6 = 3'd6,
        T7 = 3'd7
    } tState;

    typedef enum logic [1:0] {
        none = 2'd0,
        rstI = 2'd1,
        nmiI = 2'd2,
        irqI = 2'd3
    } intSource;

    typedef struct packed {
        instrClass  cls;     // [5:4]
        logic [2:0] cycles;  // base count, T1 included
        logic       wb;      // register load lands in T2 of the next instruction
    } decodeInfo;

endpackage
